//--- dv/tb_cart_loader.sv
// Cartridge loader testbench
`timescale 1ns/1ps

module tb_cart_loader;
	import cart_pkg::*;

	localparam int STREAM_WORDS = 40;
	localparam int SWAP_WORDS = 16;
	// File length that ends with address bits 13 and 9 set
	localparam int POP_END = 'h2200;
	// About six cycles per word on average with the random ack delay
	localparam int CYCLE_LIMIT = 4 * 6 * (POP_END / 2 + STREAM_WORDS + SWAP_WORDS) + 1000;
	localparam logic [31:0] SEED = 32'h2735_c82d;

	logic                   clk_sys = 1'b0;
	logic                   rst;
	logic                   download;
	logic [INDEX_W-1:0]     index;
	logic                   host_wr;
	logic [HOST_ADDR_W-1:0] host_addr;
	logic [WORD_W-1:0]      host_data;
	logic                   swap_en;
	logic                   mem_ack;
	logic                   host_wait;
	logic                   mem_req;
	logic [ROM_ADDR_W-1:0]  mem_addr;
	logic [WORD_W-1:0]      mem_data;
	logic [7:0]             rom_size;
	logic                   rom_pop;
	logic                   sgx;
	cheat_code_t            code;
	logic                   code_load;

	// ROM contents as seen by the memory model
	logic [WORD_W-1:0] rom_mem [logic [ROM_ADDR_W-1:0]];
	logic [31:0] data_lfsr;
	logic [31:0] delay_lfsr;
	int error_count;
	int test_count;
	int cycle_count = 0;

	cart_loader_top UUT (.*);

	always #10 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
			$display("Verification failed");
			$finish;
		end else begin
			cycle_count <= cycle_count + 1;
		end
	end

	// ============================================================
	// Helpers
	// ============================================================

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] lfsr_bits(inout logic [31:0] state, input int n);
		logic [31:0] bits;
		bits = '0;
		repeat (n) begin
			bits = {bits[30:0], state[0]};
			state = state[0] ? ((state >> 1) ^ 32'hB4BC_D35C) : (state >> 1);
		end
		return bits;
	endfunction

	function automatic logic [WORD_W-1:0] reverse_word(input logic [WORD_W-1:0] w);
		logic [WORD_W-1:0] r;
		logic [WORD_W-1:0] rest;
		r = '0;
		rest = w;
		repeat (WORD_W) begin
			r = {r[WORD_W-2:0], rest[0]};
			rest = rest >> 1;
		end
		return r;
	endfunction

	// Title string words in both blocks, block B carries one bad word
	function automatic logic [WORD_W-1:0] title_word(input logic [ROM_ADDR_W-1:0] a);
		logic [WORD_W-1:0] w;
		w = a[15:0] ^ 16'h5A5A;
		if (a[23:4] == 20'h00212 || a[23:4] == 20'h001F2) begin
			case (a[3:0])
				4'd6:    w = 16'h4F50;
				4'd8:    w = 16'h5550;
				4'd10:   w = a[13] ? 16'h4F4C : 16'h4E4C;
				4'd12:   w = 16'h5355;
				default: ;
			endcase
		end
		return w;
	endfunction

	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("FAILED %s: expected %h, got %h", name, expected, actual);
		error_count++;
	endtask

	// Memory side of the toggle handshake
	initial begin : memory_model
		logic [2:0] delay;
		mem_ack = 1'b0;
		delay_lfsr = SEED;
		forever begin
			step();
			if (mem_req !== mem_ack) begin
				delay = 3'(lfsr_bits(delay_lfsr, 3));
				repeat (delay) step();
				rom_mem[mem_addr] = mem_data;
				mem_ack = mem_req;
			end
		end
	end

	// ============================================================
	// Download port tasks
	// ============================================================

	task automatic start_cart(input logic [INDEX_W-1:0] idx, input logic swap);
		index = idx;
		swap_en = swap;
		download = 1'b1;
		step();
		if (mem_addr !== '0) report_mismatch("mem_addr", 32'd0, 32'(mem_addr));
		if (rom_pop !== 1'b1) report_mismatch("rom_pop", 32'd1, 32'(rom_pop));
	endtask

	task automatic end_download();
		download = 1'b0;
		step();
	endtask

	task automatic send_cart_word(input logic [WORD_W-1:0] w);
		logic [ROM_ADDR_W-1:0] addr_before;
		logic req_before;
		int waited;
		addr_before = mem_addr;
		req_before = mem_req;
		waited = 0;
		host_addr = HOST_ADDR_W'(addr_before);
		host_data = w;
		host_wr = 1'b1;
		step();
		host_wr = 1'b0;
		if (host_wait !== 1'b1) report_mismatch("host_wait", 32'd1, 32'(host_wait));
		if (mem_req !== ~req_before) report_mismatch("mem_req", 32'(~req_before), 32'(mem_req));
		while (host_wait === 1'b1 && waited < 16) begin
			// Address holds while the memory is slow
			if (mem_addr !== addr_before)
				report_mismatch("mem_addr", 32'(addr_before), 32'(mem_addr));
			step();
			waited++;
		end
		if (host_wait !== 1'b0) begin
			$display("host_wait still high %0d cycles after a write", waited);
			error_count++;
		end else if (mem_addr !== addr_before + ROM_ADDR_W'(2)) begin
			report_mismatch("mem_addr", 32'(addr_before + ROM_ADDR_W'(2)), 32'(mem_addr));
		end
	endtask

	// ============================================================
	// Tests
	// ============================================================

	task automatic test_reset();
		test_count++;
		if (host_wait !== 1'b0) report_mismatch("host_wait", 32'd0, 32'(host_wait));
		if (mem_req !== 1'b0) report_mismatch("mem_req", 32'd0, 32'(mem_req));
		if (code_load !== 1'b0) report_mismatch("code_load", 32'd0, 32'(code_load));
		if (sgx !== 1'b0) report_mismatch("sgx", 32'd0, 32'(sgx));
		if (rom_pop !== 1'b1) report_mismatch("rom_pop", 32'd1, 32'(rom_pop));
	endtask

	task automatic test_stream(input logic swap, input int count);
		logic [WORD_W-1:0] sent [$];
		logic [WORD_W-1:0] w;
		logic [WORD_W-1:0] expected;
		logic [ROM_ADDR_W-1:0] key;
		logic [7:0] exp_size;
		test_count++;
		rom_mem.delete();
		start_cart(8'h01, swap);
		for (int i = 0; i < count; i++) begin
			w = 16'(lfsr_bits(data_lfsr, 16));
			sent.push_back(w);
			send_cart_word(w);
		end
		end_download();
		for (int i = 0; i < count; i++) begin
			key = ROM_ADDR_W'(2 * i);
			expected = swap ? reverse_word(sent[i]) : sent[i];
			if (!rom_mem.exists(key)) begin
				$display("No memory write reached address %h", key);
				error_count++;
			end else if (rom_mem[key] !== expected) begin
				report_mismatch("mem_data", 32'(expected), 32'(rom_mem[key]));
			end
		end
		exp_size = 8'(ROM_ADDR_W'(2 * count) >> 16);
		if (rom_size !== exp_size) report_mismatch("rom_size", 32'(exp_size), 32'(rom_size));
	endtask

	task automatic test_populous();
		logic [ROM_ADDR_W-1:0] addr;
		test_count++;
		start_cart(8'h01, 1'b0);
		for (int a = 0; a < POP_END; a += 2) begin
			addr = ROM_ADDR_W'(a);
			// Flag 0 drops once block B has gone by
			if (addr == 24'h001C00 && rom_pop !== 1'b1)
				report_mismatch("rom_pop", 32'd1, 32'(rom_pop));
			if (addr == 24'h002000 && rom_pop !== 1'b0)
				report_mismatch("rom_pop", 32'd0, 32'(rom_pop));
			send_cart_word(title_word(addr));
		end
		if (rom_pop !== 1'b1) report_mismatch("rom_pop", 32'd1, 32'(rom_pop));
		end_download();
	endtask

	task automatic test_sgx();
		test_count++;
		start_cart(8'h22, 1'b0);
		if (sgx !== 1'b1) report_mismatch("sgx", 32'd1, 32'(sgx));
		end_download();
		if (sgx !== 1'b1) report_mismatch("sgx", 32'd1, 32'(sgx));
		start_cart(8'h01, 1'b0);
		if (sgx !== 1'b0) report_mismatch("sgx", 32'd0, 32'(sgx));
		end_download();
	endtask

	task automatic test_cheat();
		logic [WORD_W-1:0] words [8];
		cheat_code_t expected;
		test_count++;
		index = 8'hFF;
		download = 1'b1;
		step();
		for (int i = 0; i < 8; i++) begin
			words[i] = 16'(lfsr_bits(data_lfsr, 16));
			host_addr = HOST_ADDR_W'(2 * i);
			host_data = words[i];
			host_wr = 1'b1;
			step();
			host_wr = 1'b0;
			if (host_wait !== 1'b0) report_mismatch("host_wait", 32'd0, 32'(host_wait));
			if (code_load !== (i == 7))
				report_mismatch("code_load", 32'(i == 7), 32'(code_load));
		end
		expected.flags = {words[1], words[0]};
		expected.address = {words[3], words[2]};
		expected.compare = {words[5], words[4]};
		expected.replace = {words[7], words[6]};
		if (code.flags !== expected.flags)
			report_mismatch("code.flags", expected.flags, code.flags);
		if (code.address !== expected.address)
			report_mismatch("code.address", expected.address, code.address);
		if (code.compare !== expected.compare)
			report_mismatch("code.compare", expected.compare, code.compare);
		if (code.replace !== expected.replace)
			report_mismatch("code.replace", expected.replace, code.replace);
		step();
		if (code_load !== 1'b0) report_mismatch("code_load", 32'd0, 32'(code_load));
		download = 1'b0;
		index = '0;
		step();
	endtask

	// ============================================================
	// Main sequence
	// ============================================================

	initial begin
		rst = 1'b1;
		download = 1'b0;
		index = '0;
		host_wr = 1'b0;
		host_addr = '0;
		host_data = '0;
		swap_en = 1'b0;
		data_lfsr = SEED;
		error_count = 0;
		test_count = 0;
		repeat (8) @(posedge clk_sys);
		#1;
		rst = 1'b0;

		test_reset();
		test_stream(1'b0, STREAM_WORDS);
		test_stream(1'b1, SWAP_WORDS);
		test_populous();
		test_sgx();
		test_cheat();

		$display("Tests run: %0d, errors: %0d", test_count, error_count);
		if (error_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- files.f
src/cart_pkg.sv
src/download_port.sv
src/populous_detect.sv
src/cheat_assembler.sv
src/rom_write_channel.sv
src/cart_loader_top.sv
dv/tb_cart_loader.sv

//--- run.sh
#!/bin/sh
# Compile and run the cartridge loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_cart_loader -o tb_cart_loader

out=$(./obj_dir/tb_cart_loader)
echo "$out"

if echo "$out" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1

//--- src/cart_loader_top.sv
// Cartridge loader top level
`timescale 1ns/1ps

module cart_loader_top (
	input  logic                             clk_sys,
	input  logic                             rst,
	input  logic                             download,
	input  logic [cart_pkg::INDEX_W-1:0]     index,
	input  logic                             host_wr,
	input  logic [cart_pkg::HOST_ADDR_W-1:0] host_addr,
	input  logic [cart_pkg::WORD_W-1:0]      host_data,
	input  logic                             swap_en,
	input  logic                             mem_ack,
	output logic                             host_wait,
	output logic                             mem_req,
	output logic [cart_pkg::ROM_ADDR_W-1:0]  mem_addr,
	output logic [cart_pkg::WORD_W-1:0]      mem_data,
	output logic [7:0]                       rom_size,
	output logic                             rom_pop,
	output logic                             sgx,
	output cart_pkg::cheat_code_t            code,
	output logic                             code_load
);
	import cart_pkg::*;

	logic              cart_start;
	logic              cart_wr;
	logic              code_wr;
	logic              write_done;
	logic [WORD_W-1:0] rom_word;

	// Size in 64 KiB units
	assign rom_size = mem_addr[ROM_ADDR_W-1:ROM_ADDR_W-8];

	download_port u_download_port (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.download   (download),
		.index      (index),
		.host_wr    (host_wr),
		.write_done (write_done),
		.cart_start (cart_start),
		.cart_wr    (cart_wr),
		.code_wr    (code_wr),
		.host_wait  (host_wait),
		.sgx        (sgx)
	);

	populous_detect u_populous_detect (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.host_data  (host_data),
		.swap_en    (swap_en),
		.cart_start (cart_start),
		.cart_wr    (cart_wr),
		.rom_addr   (mem_addr),
		.rom_word   (rom_word),
		.rom_pop    (rom_pop)
	);

	cheat_assembler u_cheat_assembler (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.code_wr   (code_wr),
		.host_addr (host_addr[3:0]),
		.host_data (host_data),
		.code      (code),
		.code_load (code_load)
	);

	rom_write_channel u_rom_write_channel (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.cart_start (cart_start),
		.cart_wr    (cart_wr),
		.rom_word   (rom_word),
		.mem_ack    (mem_ack),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_data   (mem_data),
		.write_done (write_done)
	);

endmodule

//--- src/cart_pkg.sv
// Cartridge loader shared definitions

package cart_pkg;

	// ============================================================
	// Host port and ROM widths
	// ============================================================

	// Download data word from the host
	localparam int WORD_W = 16;
	// ROM byte address
	localparam int ROM_ADDR_W = 24;
	// Host download address
	localparam int HOST_ADDR_W = 25;
	// Download file index
	localparam int INDEX_W = 8;

	// Index of a cheat code download
	localparam logic [INDEX_W-1:0] CODE_INDEX = '1;
	// Low index bits of a SuperGrafx file
	localparam logic [4:0] SGX_INDEX = 5'd2;

	// ============================================================
	// Populous title signature
	// ============================================================

	// Upper address bits of the two 16-byte title blocks
	localparam logic [ROM_ADDR_W-5:0] SIG_BLOCK_A = 20'h00212;
	localparam logic [ROM_ADDR_W-5:0] SIG_BLOCK_B = 20'h001F2;

	// Expected words at block offsets 6, 8, 10 and 12
	localparam logic [WORD_W-1:0] SIG_WORD_0 = 16'h4F50;
	localparam logic [WORD_W-1:0] SIG_WORD_1 = 16'h5550;
	localparam logic [WORD_W-1:0] SIG_WORD_2 = 16'h4F4C;
	localparam logic [WORD_W-1:0] SIG_WORD_3 = 16'h5355;

	// Cheat code, flags in the top word
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

//--- src/cheat_assembler.sv
// Cheat code assembly
`timescale 1ns/1ps

module cheat_assembler (
	input  logic                        clk_sys,
	input  logic                        rst,
	input  logic                        code_wr,
	input  logic [3:0]                  host_addr,
	input  logic [cart_pkg::WORD_W-1:0] host_data,
	output cart_pkg::cheat_code_t       code,
	output logic                        code_load
);

	// Eight words per code, low half of each field first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (host_addr)
				4'd0:  code.flags[15:0]    <= host_data;
				4'd2:  code.flags[31:16]   <= host_data;
				4'd4:  code.address[15:0]  <= host_data;
				4'd6:  code.address[31:16] <= host_data;
				4'd8:  code.compare[15:0]  <= host_data;
				4'd10: code.compare[31:16] <= host_data;
				4'd12: code.replace[15:0]  <= host_data;
				4'd14: code.replace[31:16] <= host_data;
				default: ;
			endcase
		end
	end

	// Strobe once the last word is in
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			code_load <= 1'b0;
		end else begin
			code_load <= code_wr && (host_addr == 4'd14);
		end
	end

	// Load strobe never repeats back to back
	a_load_single : assert property (
		@(posedge clk_sys) disable iff (rst)
		code_load |=> !code_load
	);

endmodule

//--- src/download_port.sv
// Host download port decode
`timescale 1ns/1ps

module download_port (
	input  logic                         clk_sys,
	input  logic                         rst,
	input  logic                         download,
	input  logic [cart_pkg::INDEX_W-1:0] index,
	input  logic                         host_wr,
	input  logic                         write_done,
	output logic                         cart_start,
	output logic                         cart_wr,
	output logic                         code_wr,
	output logic                         host_wait,
	output logic                         sgx
);
	import cart_pkg::*;

	logic code_sel;
	logic cart_dl;
	logic cart_dl_q;

	// All ones in the index marks a cheat file
	assign code_sel = (index == CODE_INDEX);
	assign cart_dl  = download & ~code_sel;

	// First cycle of a cartridge download
	assign cart_start = cart_dl & ~cart_dl_q;

	assign cart_wr = host_wr & cart_dl;
	assign code_wr = host_wr & download & code_sel;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cart_dl_q <= 1'b0;
			host_wait <= 1'b0;
			sgx       <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			if (cart_start) begin
				sgx <= (index[4:0] == SGX_INDEX);
			end else if (cart_wr) begin
				// Hold the host off until the memory has the word
				host_wait <= 1'b1;
			end else if (write_done) begin
				host_wait <= 1'b0;
			end
		end
	end

	// Host must respect the wait flag
	a_no_wr_in_wait : assert property (
		@(posedge clk_sys) disable iff (rst)
		host_wait |-> !host_wr
	);

endmodule

//--- src/populous_detect.sv
// Word swap and Populous signature check
`timescale 1ns/1ps

module populous_detect (
	input  logic                            clk_sys,
	input  logic                            rst,
	input  logic [cart_pkg::WORD_W-1:0]     host_data,
	input  logic                            swap_en,
	input  logic                            cart_start,
	input  logic                            cart_wr,
	input  logic [cart_pkg::ROM_ADDR_W-1:0] rom_addr,
	output logic [cart_pkg::WORD_W-1:0]     rom_word,
	output logic                            rom_pop
);
	import cart_pkg::*;

	logic [WORD_W-1:0] reversed;
	logic [WORD_W-1:0] sig_word;
	logic              sig_check;
	logic              in_block;
	// One flag per title block, selected by address bit 13
	logic [1:0]        pop_flag;

	// Full bit reversal of the host word
	assign reversed = {<<{host_data}};
	assign rom_word = swap_en ? reversed : host_data;

	assign in_block = (rom_addr[ROM_ADDR_W-1:4] == SIG_BLOCK_A) ||
		(rom_addr[ROM_ADDR_W-1:4] == SIG_BLOCK_B);

	// Expected word for the current offset
	always_comb begin
		sig_check = in_block;
		sig_word  = SIG_WORD_0;
		case (rom_addr[3:0])
			4'd6:    sig_word  = SIG_WORD_0;
			4'd8:    sig_word  = SIG_WORD_1;
			4'd10:   sig_word  = SIG_WORD_2;
			4'd12:   sig_word  = SIG_WORD_3;
			default: sig_check = 1'b0;
		endcase
	end

	// ============================================================
	// Signature flags
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			pop_flag <= 2'b11;
		end else if (cart_start) begin
			pop_flag <= 2'b11;
		end else if (cart_wr && sig_check && (rom_word != sig_word)) begin
			pop_flag[rom_addr[13]] <= 1'b0;
		end
	end

	// Bit 9 is set when the file carries a 512-byte header
	assign rom_pop = pop_flag[rom_addr[9]];

endmodule

//--- src/rom_write_channel.sv
// ROM memory write channel
`timescale 1ns/1ps

module rom_write_channel (
	input  logic                            clk_sys,
	input  logic                            rst,
	input  logic                            cart_start,
	input  logic                            cart_wr,
	input  logic [cart_pkg::WORD_W-1:0]     rom_word,
	input  logic                            mem_ack,
	output logic                            mem_req,
	output logic [cart_pkg::ROM_ADDR_W-1:0] mem_addr,
	output logic [cart_pkg::WORD_W-1:0]     mem_data,
	output logic                            write_done
);
	import cart_pkg::*;

	logic pending;

	// Memory has copied the request level
	assign write_done = pending && (mem_ack == mem_req);

	// ============================================================
	// Request toggle and address counter
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			mem_req  <= 1'b0;
			mem_addr <= '0;
			pending  <= 1'b0;
		end else if (cart_start) begin
			mem_addr <= '0;
		end else if (cart_wr) begin
			// One level change per word
			mem_req <= ~mem_req;
			pending <= 1'b1;
		end else if (write_done) begin
			pending  <= 1'b0;
			mem_addr <= mem_addr + ROM_ADDR_W'(2);
		end
	end

	// Write data, held for the whole request
	always_ff @(posedge clk_sys) begin
		if (cart_wr && !cart_start) begin
			mem_data <= rom_word;
		end
	end

	// ============================================================
	// Checks
	// ============================================================

	// Only one word in flight
	a_wr_not_pending : assert property (
		@(posedge clk_sys) disable iff (rst)
		pending |-> !cart_wr
	);

	// Data must not move under an open request
	a_data_stable : assert property (
		@(posedge clk_sys) disable iff (rst)
		pending && !write_done |=> $stable(mem_data)
	);

endmodule
